// ==== Bender.yml ====
package:
  name: cpu_2432

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_2432_pkg.sv
      - hdl/cpu_2432_regfile.sv
      - hdl/cpu_2432_alu.sv
      - hdl/cpu_2432_decode.sv
      - hdl/cpu_2432_pc_ctrl.sv
      - hdl/cpu_2432.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/cpu_2432_tb.sv

// ==== cpu_2432.f ====
+incdir+hdl
hdl/cpu_2432_pkg.sv
hdl/cpu_2432_regfile.sv
hdl/cpu_2432_alu.sv
hdl/cpu_2432_decode.sv
hdl/cpu_2432_pc_ctrl.sv
hdl/cpu_2432.sv
dv/cpu_2432_tb.sv

// ==== dv/cpu_2432_tb.sv ====
`timescale 1ns/1ps
`include "cpu_2432_defines.svh"

module cpu_2432_tb;

  localparam int MEM_DEPTH     = 256;
  localparam int TESTS_DEPTH   = 512;
  localparam int PROG_BASE     = 'h10;  // Word offsets inside the stimulus file
  localparam int LOAD_BASE     = 'h80;
  localparam int EXP_BASE      = 'ha0;
  localparam int RESET_CYCLES  = 16;
  localparam int STORE_TIMEOUT = 200;

  logic                    i_clk;
  logic                    i_rstb;
  logic [`CPU_INSTR_W-1:0] i_instr;
  logic [`CPU_DATA_W-1:0]  i_din;
  logic [`CPU_ADDR_W-1:0]  o_iaddr;
  logic [`CPU_ADDR_W-1:0]  o_daddr;
  logic [`CPU_DATA_W-1:0]  o_dout;
  logic                    o_ram_rd;
  logic [3:0]              o_ram_wr;

  logic [31:0]             tests [TESTS_DEPTH];
  logic [`CPU_INSTR_W-1:0] imem [MEM_DEPTH];
  logic [`CPU_DATA_W-1:0]  dmem [MEM_DEPTH];
  int                      n_instr;
  int                      n_load;
  int                      n_exp;
  int                      n_seen;

  cpu_2432 cpu_2432_inst (
    .i_clk   (i_clk),
    .i_rstb  (i_rstb),
    .i_instr (i_instr),
    .i_din   (i_din),
    .o_iaddr (o_iaddr),
    .o_daddr (o_daddr),
    .o_dout  (o_dout),
    .o_ram_rd(o_ram_rd),
    .o_ram_wr(o_ram_wr)
  );

  always #2 i_clk = ~i_clk;

  // Unused words decode as MOVI R15 with a value folded from the address
  function automatic logic [`CPU_INSTR_W-1:0] instr_fill(input logic [`CPU_ADDR_W-1:0] addr);
    logic [13:0] v;
    v = addr[13:0] ^ {4'h0, addr[23:14]};
    return {6'b0, v[5:4], 4'hf, v[13:6], v[3:0]};
  endfunction

  function automatic logic [`CPU_DATA_W-1:0] data_fill(input logic [`CPU_ADDR_W-1:0] addr);
    return 32'hd000_0000 ^ {8'h0, addr};
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: time %0d ns, %s = %h, expected %h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic load_tests();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      imem[a] = instr_fill(a);
      dmem[a] = data_fill(a);
    end
    $readmemh("dv/cpu_2432_tests.txt", tests);
    n_instr = tests[0];
    n_load  = tests[1];
    n_exp   = tests[2];
    if (n_exp == 0 || n_instr == 0 || n_instr > LOAD_BASE - PROG_BASE) begin
      abort_run("Stimulus file is missing or its counts are out of range");
    end else begin
      for (int i = 0; i < n_instr; i++)
        imem[i] = tests[PROG_BASE + i][`CPU_INSTR_W-1:0];
      for (int i = 0; i < n_load; i++)
        dmem[tests[LOAD_BASE + 2*i]] = tests[LOAD_BASE + 2*i + 1];
    end
  endtask

  // Instruction word and load data for the coming rising edge
  task automatic drive_inputs();
    i_instr = (o_iaddr < MEM_DEPTH) ? imem[o_iaddr] : instr_fill(o_iaddr);
    if (!o_ram_rd)
      i_din = 32'hbadc_0ffe;  // Not sampled outside a load
    else
      i_din = (o_daddr < MEM_DEPTH) ? dmem[o_daddr] : data_fill(o_daddr);
  endtask

  task automatic service_store(output bit seen);
    seen = 1'b0;
    if (o_ram_wr != 4'b0000) begin
      seen = 1'b1;
      check_value("o_ram_wr", {28'h0, o_ram_wr}, 32'hf);  // Whole word only
      check_value("o_daddr", {8'h0, o_daddr}, tests[EXP_BASE + 2*n_seen]);
      check_value("o_dout", o_dout, tests[EXP_BASE + 2*n_seen + 1]);
      if (o_daddr < MEM_DEPTH)
        dmem[o_daddr] = o_dout;
      n_seen++;
    end
  endtask

  initial begin
    bit stored;
    int idle;
    i_clk     = 1'b0;
    i_rstb    = 1'b0;
    i_instr   = '0;
    i_din     = '0;
    n_seen    = 0;
    load_tests();
    repeat (RESET_CYCLES) begin
      @(negedge i_clk);
      drive_inputs();
    end
    // State still held by reset
    check_value("o_iaddr", {8'h0, o_iaddr}, 32'h0);
    check_value("o_ram_rd", {31'h0, o_ram_rd}, 32'h0);
    check_value("o_ram_wr", {28'h0, o_ram_wr}, 32'h0);
    i_rstb = 1'b1;
    idle   = 0;
    while (n_seen < n_exp) begin
      @(negedge i_clk);
      service_store(stored);
      drive_inputs();
      if (stored)
        idle = 0;
      else
        idle++;
      if (idle >= STORE_TIMEOUT)
        abort_run($sformatf("Timeout: no store for %0d cycles after %0d of %0d, fetch at %h",
                            STORE_TIMEOUT, n_seen, n_exp, o_iaddr));
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== dv/cpu_2432_tests.txt ====
// Hex words, @ sets the word index. @000 holds the counts: program words, preloads, stores
// @010 program (24-bit words), @080 preload pairs (address data), @0a0 stores (address data)
@000
00000041 00000002 00000011
@010
031484 002005 8F31FD 220300  // MOVI R1 R2, ADD -3, store with stall
904120 9752F8 220401 220502  // SUB reg, SUB -8
0360F0 A676AA AC82C0 B791FF  // AND OR XOR with zero extended immediates
220703 220804 220905
A0A190 A8BA20 B0CB10 220C06  // Dependent register chain
88D240 90D2D0 220D07         // Negative result
C4E008 8CEE01 220E08         // Load by immediate, used next
003009 C04030 220409         // Load by register
001007 002009 980120 481003 22010A  // CMP 7,9 then EQ not taken
48C003 22020B 22020C 22020D         // LT taken, two stores flushed
9C0209 482005 489005 48B003 22010E 22010F 230200  // Z set, NE HI not taken, GE taken
9C0E03 48B004 487003 230101 230102 230103         // Overflow, GE not taken, VS taken
006003 946601 4B20FF 230604  // Count down loop on NE
43000A 230105 230106 230107  // JMP over stores
980210 484003 48D003 230108 230109 23050A 23020F  // CC not taken, GT taken, sentinel
@080
00000008 80000001
00000009 0000ABCD
@0a0
00000020 00001231
00000021 0000122F
00000022 0000000D
00000023 000002A0
00000024 00000305
00000025 000011CB
00000026 00000231
00000027 FFFFEDD1
00000028 80000002
00000029 0000ABCD
0000002A 00000007
0000002D 00000009
00000030 00000009
00000033 00000007
00000034 00000000
0000003A 0000000D
0000003F 00000009

// ==== hdl/cpu_2432.sv ====
`timescale 1ns/1ps
`include "cpu_2432_defines.svh"

module cpu_2432 (
  input  logic                    i_clk,
  input  logic                    i_rstb,
  input  logic [`CPU_INSTR_W-1:0] i_instr,
  input  logic [`CPU_DATA_W-1:0]  i_din,
  output logic [`CPU_ADDR_W-1:0]  o_iaddr,
  output logic [`CPU_ADDR_W-1:0]  o_daddr,
  output logic [`CPU_DATA_W-1:0]  o_dout,
  output logic                    o_ram_rd,
  output logic [3:0]              o_ram_wr
);

  cpu_2432_pkg::dec_t     dec;
  cpu_2432_pkg::ex_t      ex_d;
  cpu_2432_pkg::ex_t      ex_q;
  cpu_2432_pkg::psr_t     psr_d;
  cpu_2432_pkg::psr_t     psr_q;
  cpu_2432_pkg::psr_t     alu_psr;
  logic                   stall;
  logic                   flush;
  logic                   ex_is_ld;
  logic                   ex_is_sto;
  logic                   wb_we;
  logic [`CPU_DATA_W-1:0] rf_rdata_0;
  logic [`CPU_DATA_W-1:0] rf_rdata_1;
  logic [`CPU_DATA_W-1:0] alu_result;
  logic [`CPU_DATA_W-1:0] wb_data;

  cpu_2432_decode u_decode (
    .i_clk    (i_clk),
    .i_rstb   (i_rstb),
    .i_instr  (i_instr),
    .i_iaddr  (o_iaddr),
    .i_flush  (flush),
    .i_ex_rdst(ex_q.rdst),
    .i_ex_wr  (wb_we),
    .o_dec    (dec),
    .o_stall  (stall)
  );

  cpu_2432_regfile u_regfile (
    .i_clk    (i_clk),
    .i_rstb   (i_rstb),
    .i_we     (wb_we),
    .i_waddr  (ex_q.rdst),
    .i_wdata  (wb_data),
    .i_raddr_0(dec.rsrc0),
    .i_raddr_1(dec.rsrc1),
    .o_rdata_0(rf_rdata_0),
    .o_rdata_1(rf_rdata_1)
  );

  cpu_2432_alu u_alu (
    .i_opcode(ex_q.opcode),
    .i_a     (ex_q.src0),
    .i_b     (ex_q.ead),
    .i_psr   (psr_q),
    .o_result(alu_result),
    .o_psr   (alu_psr)
  );

  cpu_2432_pc_ctrl u_pc_ctrl (
    .i_clk  (i_clk),
    .i_rstb (i_rstb),
    .i_ex   (ex_q),
    .i_psr  (psr_q),
    .i_stall(stall),
    .o_iaddr(o_iaddr),
    .o_flush(flush)
  );

  // Operand select, bubble on stall or flush
  always_comb begin
    ex_d.valid  = dec.valid & ~stall & ~flush;
    ex_d.opcode = dec.opcode;
    ex_d.rdst   = dec.rdst;
    ex_d.rf_wr  = dec.rf_wr;
    ex_d.cond   = dec.cond;
    ex_d.pc     = dec.pc;
    ex_d.src0   = rf_rdata_0;
    ex_d.ead    = dec.use_imm ? dec.imm : rf_rdata_1;
  end

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb)
      ex_q <= '0;
    else
      ex_q <= ex_d;
  end

  // Data memory port
  assign ex_is_ld  = ex_q.valid & (ex_q.opcode == `LD_W);
  assign ex_is_sto = ex_q.valid & (ex_q.opcode == `STO_W);
  assign o_daddr   = ex_q.ead[`CPU_ADDR_W-1:0];
  assign o_dout    = ex_q.src0;
  assign o_ram_rd  = ex_is_ld;
  assign o_ram_wr  = {4{ex_is_sto}};  // Whole word only

  // Writeback
  assign wb_we   = ex_q.valid & ex_q.rf_wr;
  assign wb_data = ex_is_ld ? i_din : alu_result;

  always_comb begin
    psr_d = psr_q;
    if (ex_is_ld) begin
      psr_d.z = ~|i_din;
      psr_d.s = i_din[`CPU_DATA_W-1];
    end else if (ex_q.valid) begin
      psr_d = alu_psr;  // ALU keeps flags for MOVI, stores and jumps
    end
  end

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb)
      psr_q <= '0;
    else
      psr_q <= psr_d;
  end

endmodule

// ==== hdl/cpu_2432_alu.sv ====
`timescale 1ns/1ps
`include "cpu_2432_defines.svh"

module cpu_2432_alu (
  input  logic [`CPU_OPC_W-1:0]  i_opcode,
  input  logic [`CPU_DATA_W-1:0] i_a,
  input  logic [`CPU_DATA_W-1:0] i_b,
  input  cpu_2432_pkg::psr_t     i_psr,
  output logic [`CPU_DATA_W-1:0] o_result,
  output cpu_2432_pkg::psr_t     o_psr
);

  localparam int MSB = `CPU_DATA_W - 1;

  logic [`CPU_DATA_W:0] add_sum;
  logic [`CPU_DATA_W:0] sub_sum;
  logic                 flag_upd;
  logic                 carry;
  logic                 ovf;

  assign add_sum = {1'b0, i_a} + {1'b0, i_b};
  assign sub_sum = {1'b0, i_a} + {1'b0, ~i_b} + 1'b1;  // Carry set means no borrow

  always_comb begin
    o_result = i_b;
    flag_upd = 1'b1;
    carry    = 1'b0;
    ovf      = 1'b0;
    case (i_opcode)
      `MOV: o_result = i_b;
      `ADD: begin
        o_result = add_sum[MSB:0];
        carry    = add_sum[`CPU_DATA_W];
        ovf      = (i_a[MSB] == i_b[MSB]) & (add_sum[MSB] != i_a[MSB]);
      end
      `SUB, `CMP: begin
        o_result = sub_sum[MSB:0];
        carry    = sub_sum[`CPU_DATA_W];
        ovf      = (i_a[MSB] != i_b[MSB]) & (sub_sum[MSB] != i_a[MSB]);
      end
      `AND: o_result = i_a & i_b;
      `OR:  o_result = i_a | i_b;
      `XOR: o_result = i_a ^ i_b;
      default: flag_upd = 1'b0;  // MOVI passes its immediate, flags kept
    endcase
  end

  always_comb begin
    o_psr = i_psr;
    if (flag_upd) begin
      o_psr.z = ~|o_result;
      o_psr.s = o_result[MSB];
      o_psr.c = carry;
      o_psr.v = ovf;
    end
  end

endmodule

// ==== hdl/cpu_2432_decode.sv ====
`timescale 1ns/1ps
`include "cpu_2432_defines.svh"

module cpu_2432_decode (
  input  logic                   i_clk,
  input  logic                   i_rstb,
  input  logic [`CPU_INSTR_W-1:0] i_instr,
  input  logic [`CPU_ADDR_W-1:0] i_iaddr,
  input  logic                   i_flush,
  input  logic [`CPU_REG_AW-1:0] i_ex_rdst,
  input  logic                   i_ex_wr,
  output cpu_2432_pkg::dec_t     o_dec,
  output logic                   o_stall
);

  cpu_2432_pkg::dec_t dec_d;

  // Unpack the fetched word by format
  always_comb begin
    dec_d         = '0;
    dec_d.valid   = 1'b1;
    dec_d.pc      = i_iaddr;
    dec_d.opcode  = {i_instr[`OPC_RNG], 1'b0};
    dec_d.use_imm = i_instr[`IMM_BIT];
    dec_d.rdst    = i_instr[`RDST_RNG];
    dec_d.rsrc0   = i_instr[`RSRC0_RNG];
    dec_d.rsrc1   = i_instr[`RSRC1_RNG];
    dec_d.rf_wr   = 1'b1;
    case (i_instr[23:21])
      3'b000: begin // Format A
        dec_d.opcode  = `MOVI;
        dec_d.use_imm = 1'b1;
        dec_d.rsrc0   = '0;
        dec_d.rsrc1   = '0;
        dec_d.imm     = {18'b0, i_instr[11:4], i_instr[17:16], i_instr[3:0]};
      end
      3'b001: begin // Format B, rsrc0 holds the data register
        dec_d.opcode  = `STO_W;
        dec_d.use_imm = 1'b1;
        dec_d.rf_wr   = 1'b0;
        dec_d.rdst    = '0;
        dec_d.rsrc1   = '0;
        dec_d.imm     = {18'b0, i_instr[15:12], i_instr[7:4], i_instr[17:16], i_instr[3:0]};
      end
      3'b010: begin // Format C
        dec_d.use_imm = 1'b1;
        dec_d.rf_wr   = 1'b0;
        dec_d.rdst    = '0;
        dec_d.rsrc0   = '0;
        dec_d.rsrc1   = '0;
        if (dec_d.opcode == `JMP) begin
          dec_d.imm = {18'b0, i_instr[11:4], i_instr[17:16], i_instr[3:0]};
        end else begin
          dec_d.opcode = `JRCC;
          dec_d.imm    = {{22{i_instr[7]}}, i_instr[7:4], i_instr[17:16], i_instr[3:0]};
          dec_d.cond   = i_instr[`RDST_RNG];  // Condition sits in the dest field
        end
      end
      default: begin // Format E
        if (dec_d.opcode == `CMP)
          dec_d.rf_wr = 1'b0;
        if (dec_d.use_imm)
          dec_d.rsrc1 = '0;
        if (dec_d.opcode == `MOV || dec_d.opcode == `LD_W)
          dec_d.rsrc0 = '0;  // Only the second operand is used
        if (dec_d.opcode == `ADD || dec_d.opcode == `SUB || dec_d.opcode == `CMP)
          dec_d.imm = {{22{i_instr[7]}}, i_instr[7:4], i_instr[17:16], i_instr[3:0]};
        else
          dec_d.imm = {22'b0, i_instr[7:4], i_instr[17:16], i_instr[3:0]};
      end
    endcase
  end

  // Execute result not yet written back, so wait one cycle
  assign o_stall = o_dec.valid & i_ex_wr &
                   ((i_ex_rdst == o_dec.rsrc0) | (i_ex_rdst == o_dec.rsrc1));

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      o_dec <= '0;
    end else if (i_flush) begin
      o_dec.valid <= 1'b0;  // Word behind a taken jump
    end else if (!o_stall) begin
      o_dec <= dec_d;
    end
  end

endmodule

// ==== hdl/cpu_2432_defines.svh ====
`ifndef CPU_2432_DEFINES_SVH
`define CPU_2432_DEFINES_SVH

// Datapath widths
`define CPU_DATA_W  32
`define CPU_INSTR_W 24
`define CPU_ADDR_W  24
`define CPU_REG_AW  4
`define CPU_OPC_W   6
`define CPU_COND_W  4

// Expanded opcodes, instruction bits 23:19 with a zero appended
`define MOVI  6'b000000  // Format A
`define STO_W 6'b001000  // Format B
`define JMP   6'b010000  // Format C
`define JRCC  6'b010010
`define MOV   6'b100000  // Format E from here on
`define ADD   6'b100010
`define SUB   6'b100100
`define CMP   6'b100110
`define AND   6'b101000
`define OR    6'b101010
`define XOR   6'b101100
`define LD_W  6'b110000

// Instruction fields
`define OPC_RNG   23:19
`define IMM_BIT   18
`define RDST_RNG  15:12
`define RSRC0_RNG 11:8
`define RSRC1_RNG 7:4

// Branch conditions, 0 and 15 mean always
`define EQ 4'd1
`define NE 4'd2
`define CS 4'd3
`define CC 4'd4
`define MI 4'd5
`define PL 4'd6
`define VS 4'd7
`define VC 4'd8
`define HI 4'd9
`define LS 4'd10
`define GE 4'd11
`define LT 4'd12
`define GT 4'd13
`define LE 4'd14

// Flag bit positions in the flag register
`define Z 0
`define S 1
`define C 2
`define V 3

`endif

// ==== hdl/cpu_2432_pc_ctrl.sv ====
`timescale 1ns/1ps
`include "cpu_2432_defines.svh"

module cpu_2432_pc_ctrl (
  input  logic                   i_clk,
  input  logic                   i_rstb,
  input  cpu_2432_pkg::ex_t      i_ex,
  input  cpu_2432_pkg::psr_t     i_psr,
  input  logic                   i_stall,
  output logic [`CPU_ADDR_W-1:0] o_iaddr,
  output logic                   o_flush
);

  logic [`CPU_ADDR_W-1:0] pc_q;
  logic [`CPU_ADDR_W-1:0] target;
  logic [3:0]             flags;
  logic                   cond_true;
  logic                   taken;

  assign flags = i_psr;

  always_comb begin
    case (i_ex.cond)
      `EQ: cond_true = flags[`Z];
      `NE: cond_true = ~flags[`Z];
      `CS: cond_true = flags[`C];                    // Unsigned higher or same
      `CC: cond_true = ~flags[`C];                   // Unsigned lower
      `MI: cond_true = flags[`S];
      `PL: cond_true = ~flags[`S];
      `VS: cond_true = flags[`V];
      `VC: cond_true = ~flags[`V];
      `HI: cond_true = flags[`C] & ~flags[`Z];
      `LS: cond_true = ~flags[`C] | flags[`Z];
      `GE: cond_true = flags[`S] == flags[`V];       // Signed
      `LT: cond_true = flags[`S] != flags[`V];
      `GT: cond_true = ~flags[`Z] & (flags[`S] == flags[`V]);
      `LE: cond_true = flags[`Z] | (flags[`S] != flags[`V]);
      default: cond_true = 1'b1;                     // Always
    endcase
  end

  assign taken = i_ex.valid &
                 ((i_ex.opcode == `JMP) | ((i_ex.opcode == `JRCC) & cond_true));

  // JMP is absolute, JRCC relative to its own address
  assign target = (i_ex.opcode == `JMP) ? i_ex.ead[`CPU_ADDR_W-1:0]
                                        : i_ex.pc + i_ex.ead[`CPU_ADDR_W-1:0];

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      pc_q <= '0;
    end else if (taken) begin
      pc_q <= target;
    end else if (!i_stall) begin
      pc_q <= pc_q + 1'b1;
    end
  end

  assign o_iaddr = pc_q;
  assign o_flush = taken;

endmodule

// ==== hdl/cpu_2432_pkg.sv ====
`include "cpu_2432_defines.svh"

package cpu_2432_pkg;

  // Flag register, z in bit 0 up to v in bit 3
  typedef struct packed {
    logic v;
    logic c;
    logic s;
    logic z;
  } psr_t;

  // One decoded instruction held in the decode register
  typedef struct packed {
    logic                   valid;
    logic [`CPU_OPC_W-1:0]  opcode;
    logic                   use_imm;    // Second operand from imm
    logic [`CPU_REG_AW-1:0] rdst;
    logic [`CPU_REG_AW-1:0] rsrc0;
    logic [`CPU_REG_AW-1:0] rsrc1;
    logic [`CPU_DATA_W-1:0] imm;        // Already extended
    logic [`CPU_COND_W-1:0] cond;
    logic                   rf_wr;
    logic [`CPU_ADDR_W-1:0] pc;         // Address the word was fetched from
  } dec_t;

  // Execute stage register
  typedef struct packed {
    logic                   valid;
    logic [`CPU_OPC_W-1:0]  opcode;
    logic [`CPU_REG_AW-1:0] rdst;
    logic                   rf_wr;
    logic [`CPU_COND_W-1:0] cond;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] src0;       // Also the store data
    logic [`CPU_DATA_W-1:0] ead;        // Effective address or second operand
  } ex_t;

endpackage

// ==== hdl/cpu_2432_regfile.sv ====
`timescale 1ns/1ps
`include "cpu_2432_defines.svh"

module cpu_2432_regfile (
  input  logic                   i_clk,
  input  logic                   i_rstb,
  input  logic                   i_we,
  input  logic [`CPU_REG_AW-1:0] i_waddr,
  input  logic [`CPU_DATA_W-1:0] i_wdata,
  input  logic [`CPU_REG_AW-1:0] i_raddr_0,
  input  logic [`CPU_REG_AW-1:0] i_raddr_1,
  output logic [`CPU_DATA_W-1:0] o_rdata_0,
  output logic [`CPU_DATA_W-1:0] o_rdata_1
);

  localparam int NUM_REGS = 1 << `CPU_REG_AW;

  logic [`CPU_DATA_W-1:0] regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Read ports see the old value during the write cycle
  assign o_rdata_0 = regs[i_raddr_0];
  assign o_rdata_1 = regs[i_raddr_1];

endmodule
